//--- dv/afe_test_patterns.txt
# wr CH N bytes: N host writes on channel CH; regs V H D: expected select, hd, vd
# dac N words / rd N bytes: expected values; play MODE BLACK; read; quiet CYCLES
test regs
wr 0 1 01
wr 1 1 02
wr 2 2 34 12
regs 1 1 0
end
test plain
wr 3 1 a0
wr 4 20 11 01 22 02 33 c3 44 0f bc 3a 55 05 66 06 77 07 88 88 99 19
dac 10 0111 0222 0333 0f44 3abc 0555 0666 0777 0888 1999
rd 20 11 01 22 02 33 03 44 0f bc 0a 55 05 66 06 77 07 88 08 99 09
wr 3 1 55
play 0 1234
read
end
test ccd
wr 3 1 a1
wr 4 6 45 23 ff ff 01 10
dac 3 2345 3fff 1001
rd 6 45 03 ff 0f 01 00
wr 3 1 55
play 1 1234
read
end
test badtag
wr 3 1 31
wr 4 2 aa bb
wr 3 1 55
quiet 40
end
test rerun
wr 2 2 00 08
wr 3 1 a0
wr 4 4 21 43 65 87
dac 2 0321 0765
rd 4 21 03 65 07
wr 3 1 55
play 0 0800
read
end

//--- dv/tb_afe_test.sv
`timescale 1ns/1ps

`include "afe_test_config.svh"

module tb_afe_test
  import afe_test_pkg::*;
();

  logic        sys_clk;
  logic        n_rst;
  logic [7:0]  master_data;
  logic [4:0]  valid_bus;
  logic        reply_rdreq;
  logic [11:0] q_fpga = 12'h000;
  logic        reply_ready;
  logic [7:0]  reply_len;
  logic [7:0]  reply_data;
  logic        video_in_select;
  dac_word_t   dac_d;
  logic        clk_fpga;
  logic        shp_fpga;
  logic        shd_fpga;
  logic        hd_fpga;
  logic        vd_fpga;
  logic        clpdm_fpga;

  int          cycle_limit = 2000;  // grows by 64 per host byte read from the patterns
  int          cycle_count;
  int          error_count;
  int          check_count;
  int          test_count;
  int          fail_count;
  int          test_errors;
  logic [63:0] test_name;
  dac_word_t   dac_q[$];  // expected dac words of the running test
  logic [7:0]  rd_q[$];   // expected readback bytes

  afe_test_top uut
  (
    .sys_clk         (sys_clk),
    .n_rst           (n_rst),
    .master_data     (master_data),
    .valid_bus       (valid_bus),
    .reply_rdreq     (reply_rdreq),
    .q_fpga          (q_fpga),
    .reply_ready     (reply_ready),
    .reply_len       (reply_len),
    .reply_data      (reply_data),
    .video_in_select (video_in_select),
    .dac_d           (dac_d),
    .clk_fpga        (clk_fpga),
    .shp_fpga        (shp_fpga),
    .shd_fpga        (shd_fpga),
    .hd_fpga         (hd_fpga),
    .vd_fpga         (vd_fpga),
    .clpdm_fpga      (clpdm_fpga)
  );

  initial
  begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  // afe model output code follows the dac one clock late
  always @(posedge sys_clk)
    q_fpga <= dac_d[11:0];

  initial
  begin
    cycle_count = 0;
    while (cycle_count <= cycle_limit)
    begin
      @(posedge sys_clk);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      $display("Fail %0s %0s: expected %b, actual %b", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_dac(input string what, input dac_word_t exp, input dac_word_t act);
    check_count++;
    if (act !== exp)
    begin
      $display("Fail %0s %0s: expected %h, actual %h", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    check_count++;
    if (act !== exp)
    begin
      $display("Fail %0s %0s: expected %h, actual %h", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  // one strobe on channel ch, then one quiet cycle
  task automatic host_write(input int ch, input logic [7:0] data);
    @(posedge sys_clk);
    master_data <= data;
    valid_bus   <= 5'(1 << ch);
    @(posedge sys_clk);
    valid_bus   <= '0;
  endtask

  task automatic run_playback(input int ccd, input dac_word_t black_dac);
    int        pixels;
    int        i;
    dac_word_t exp;
    logic      clamp_exp;
    pixels = dac_q.size();
    do
      @(negedge sys_clk);
    while (shp_fpga !== 1'b0);  // count 1 of the first pixel
    for (i = 0; i < pixels; i++)
    begin
      exp       = dac_q.pop_front();
      clamp_exp = (i % `LINE_PIXELS) < (`LINE_PIXELS - `BLANK_PIXELS);
      check_bit("shp_fpga pulse", 1'b0, shp_fpga);
      check_bit("shd_fpga idle", 1'b1, shd_fpga);
      check_bit("clk_fpga high", 1'b1, clk_fpga);
      check_bit("clpdm_fpga", clamp_exp, clpdm_fpga);
      check_dac("dac first half", (ccd != 0) ? exp : black_dac, dac_d);
      repeat (2) @(negedge sys_clk);  // count 3
      check_bit("shp_fpga after pulse", 1'b1, shp_fpga);
      @(negedge sys_clk);  // count 4
      check_bit("clk_fpga low", 1'b0, clk_fpga);
      check_dac("dac second half", exp, dac_d);
      @(negedge sys_clk);
      check_bit("shd_fpga pulse", 1'b0, shd_fpga);
      check_bit("shp_fpga idle", 1'b1, shp_fpga);
      repeat (2) @(negedge sys_clk);  // count 7
      check_bit("shd_fpga after pulse", 1'b1, shd_fpga);
      @(negedge sys_clk);  // count 0 of the next pixel
      check_bit("shp_fpga before pulse", 1'b1, shp_fpga);
      check_bit("clk_fpga rise", 1'b1, clk_fpga);
      if (i == pixels - 1)
        check_bit("clpdm_fpga after last sample", 1'b0, clpdm_fpga);
      @(negedge sys_clk);
    end
    check_bit("shp_fpga after playback", 1'b1, shp_fpga);
  endtask

  task automatic read_back();
    int         total;
    int         i;
    logic [7:0] exp;
    total = rd_q.size();
    while (reply_ready !== 1'b1)
      @(negedge sys_clk);
    check_byte("reply_len", (total > 255) ? 8'hff : 8'(total), reply_len);
    for (i = 0; i < total; i++)
    begin
      exp = rd_q.pop_front();
      @(posedge sys_clk);
      reply_rdreq <= 1'b1;
      @(posedge sys_clk);
      reply_rdreq <= 1'b0;
      @(negedge sys_clk);  // byte registered on the strobe edge
      check_byte("reply_data", exp, reply_data);
    end
    check_bit("reply_ready after last byte", 1'b0, reply_ready);
  endtask

  task automatic watch_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge sys_clk);
      check_bit("shp_fpga stays idle", 1'b1, shp_fpga);
      check_bit("reply_ready stays low", 1'b0, reply_ready);
    end
  endtask

  initial
  begin
    int            fd;
    int            code;
    int            ch;
    int            cnt;
    int            i;
    int            mode;
    logic [63:0]   cmd;
    logic [7:0]    byte_val;
    dac_word_t     word_val;
    logic          v_exp;
    logic          h_exp;
    logic          d_exp;
    logic [1023:0] skip_line;
    n_rst       = 1'b0;
    master_data = 8'h00;
    valid_bus   = 5'b00000;
    reply_rdreq = 1'b0;
    test_name   = 64'("none");
    fd = $fopen("dv/afe_test_patterns.txt", "r");
    repeat (10) @(posedge sys_clk);
    n_rst <= 1'b1;
    if (fd == 0)
    begin
      $display("could not open the pattern file dv/afe_test_patterns.txt");
      $display("SOME TESTS FAILED");
    end
    else
    begin
      while ($fscanf(fd, "%s", cmd) == 1)
      begin
        case (cmd)
          64'("#"):
            code = $fgets(skip_line, fd);
          64'("test"):
          begin
            code        = $fscanf(fd, "%s", test_name);
            test_errors = 0;
          end
          64'("wr"):
          begin
            code = $fscanf(fd, "%d %d", ch, cnt);
            for (i = 0; i < cnt; i++)
            begin
              code = $fscanf(fd, "%h", byte_val);
              cycle_limit += 64;
              host_write(ch, byte_val);
            end
          end
          64'("regs"):
          begin
            code = $fscanf(fd, "%d %d %d", v_exp, h_exp, d_exp);
            @(negedge sys_clk);
            check_bit("video_in_select", v_exp, video_in_select);
            check_bit("hd_fpga", h_exp, hd_fpga);
            check_bit("vd_fpga", d_exp, vd_fpga);
          end
          64'("dac"):
          begin
            code = $fscanf(fd, "%d", cnt);
            for (i = 0; i < cnt; i++)
            begin
              code = $fscanf(fd, "%h", word_val);
              dac_q.push_back(word_val);
            end
          end
          64'("rd"):
          begin
            code = $fscanf(fd, "%d", cnt);
            for (i = 0; i < cnt; i++)
            begin
              code = $fscanf(fd, "%h", byte_val);
              rd_q.push_back(byte_val);
            end
          end
          64'("play"):
          begin
            code = $fscanf(fd, "%d %h", mode, word_val);
            run_playback(mode, word_val);
          end
          64'("read"):
            read_back();
          64'("quiet"):
          begin
            code = $fscanf(fd, "%d", cnt);
            watch_idle(cnt);
          end
          64'("end"):
          begin
            test_count++;
            if (test_errors == 0)
              $display("test %0s passed", test_name);
            else
            begin
              fail_count++;
              $display("test %0s failed with %0d errors", test_name, test_errors);
            end
          end
          default:
          begin
            $display("unknown command %0s in the pattern file", cmd);
            error_count++;
          end
        endcase
      end
      $fclose(fd);
      $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               test_count, test_count - fail_count, fail_count, check_count, error_count);
      if (error_count == 0 && test_count > 0)
        $display("ALL TESTS PASSED");
      else
        $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/afe_pixel_timing.sv
`timescale 1ns/1ps

`include "afe_test_config.svh"

module afe_pixel_timing
  import afe_test_pkg::*;
(
  input  logic         sys_clk,
  input  logic         n_rst,
  input  run_state_e   run_state,
  input  logic         ccd_mode,
  input  logic [15:0]  black_level,
  input  sample_word_t sample_q,
  input  logic         sample_empty,
  output logic         sample_rdreq,
  output logic         capture_wrreq,
  output logic         pixel_start,
  output dac_word_t    dac_d,
  output logic         clk_fpga,
  output logic         shp_fpga,
  output logic         shd_fpga,
  output logic         clpdm_fpga
);

  localparam int PIX_W  = $clog2(`PIXEL_CLOCKS);
  localparam int LINE_W = $clog2(`LINE_PIXELS);

  // positions inside one pixel
  localparam logic [PIX_W-1:0] PIX_LAST   = PIX_W'(`PIXEL_CLOCKS - 1);
  localparam logic [PIX_W-1:0] PIX_HALF   = PIX_W'(`PIXEL_CLOCKS / 2);
  localparam logic [PIX_W-1:0] SHP_FIRST  = PIX_W'(1);
  localparam logic [PIX_W-1:0] SHP_LAST   = PIX_W'(2);
  localparam logic [PIX_W-1:0] SHD_FIRST  = PIX_W'(`PIXEL_CLOCKS / 2 + 1);
  localparam logic [PIX_W-1:0] SHD_LAST   = PIX_W'(`PIXEL_CLOCKS / 2 + 2);
  localparam logic [PIX_W-1:0] CAPTURE_AT = SHD_LAST;  // afe output settled by now

  // positions inside one clamp line
  localparam logic [LINE_W-1:0] LINE_LAST = LINE_W'(`LINE_PIXELS - 1);
  localparam logic [LINE_W-1:0] CLAMP_END = LINE_W'(`LINE_PIXELS - `BLANK_PIXELS);

  logic              playing;
  logic [PIX_W-1:0]  pix_cnt;
  logic [LINE_W-1:0] line_cnt;

  assign playing = (run_state == RUN_PLAY);

  // counters restart from zero on every entry into playback
  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      pix_cnt  <= '0;
      line_cnt <= '0;
    end
    else if (playing)
    begin
      if (pix_cnt == PIX_LAST)
      begin
        pix_cnt  <= '0;
        line_cnt <= (line_cnt == LINE_LAST) ? '0 : line_cnt + 1'b1;
      end
      else
        pix_cnt <= pix_cnt + 1'b1;
    end
    else
    begin
      pix_cnt  <= '0;
      line_cnt <= '0;
    end
  end

  assign pixel_start   = playing && (pix_cnt == '0);
  assign sample_rdreq  = playing && (pix_cnt == PIX_LAST) && !sample_empty;  // word shown all pixel
  assign capture_wrreq = playing && (pix_cnt == CAPTURE_AT);

  // sampling strobes idle high outside playback
  assign clk_fpga = !playing || (pix_cnt < PIX_HALF);
  assign shp_fpga = !(playing && (pix_cnt >= SHP_FIRST) && (pix_cnt <= SHP_LAST));
  assign shd_fpga = !(playing && (pix_cnt >= SHD_FIRST) && (pix_cnt <= SHD_LAST));

  // clamp window closes early once the samples run out
  assign clpdm_fpga = playing && (line_cnt < CLAMP_END) && !sample_empty;

  always_comb
  begin
    if (playing && (ccd_mode || (pix_cnt >= PIX_HALF)))
      dac_d = sample_q[13:0];
    else
      dac_d = black_level[13:0];  // reset phase, also parks the dac when idle
  end

endmodule

//--- rtl/afe_reg_decoder.sv
`timescale 1ns/1ps

module afe_reg_decoder
(
  input  logic        sys_clk,
  input  logic        n_rst,
  input  logic [7:0]  master_data,
  input  logic        video_sel_strobe,
  input  logic        hdvd_strobe,
  input  logic        black_strobe,
  output logic        video_in_select,
  output logic        hd_fpga,
  output logic        vd_fpga,
  output logic [15:0] black_level
);

  // single-bit settings
  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      video_in_select <= 1'b0;
      hd_fpga         <= 1'b0;
      vd_fpga         <= 1'b0;
    end
    else
    begin
      if (video_sel_strobe)
        video_in_select <= master_data[0];
      if (hdvd_strobe)
      begin
        hd_fpga <= master_data[1];
        vd_fpga <= master_data[0];
      end
    end
  end

  // black level comes in as two bytes, lsb first
  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
      black_level <= 16'h0000;
    else if (black_strobe)
      black_level <= {master_data, black_level[15:8]};  // older byte drops to the low half
  end

endmodule

//--- rtl/afe_run_sequencer.sv
`timescale 1ns/1ps

module afe_run_sequencer
  import afe_test_pkg::*;
(
  input  logic       sys_clk,
  input  logic       n_rst,
  input  logic [7:0] master_data,
  input  logic       ctrl_strobe,
  input  logic       sample_empty,
  input  logic       capture_empty,
  input  logic       pixel_start,
  output run_state_e run_state,
  output logic       ccd_mode
);

  ctrl_byte_u ctrl;
  logic       start_cmd;
  logic       stop_cmd;

  assign ctrl.raw = master_data;

  assign start_cmd = ctrl_strobe && (ctrl.start.tag == CTRL_START_TAG);
  assign stop_cmd  = ctrl_strobe && (ctrl.raw == CTRL_STOP_CODE);

  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      run_state <= RUN_IDLE;
      ccd_mode  <= 1'b0;
    end
    else
    begin
      case (run_state)
        RUN_IDLE:
        begin
          if (start_cmd)
          begin
            run_state <= RUN_LOAD;
            ccd_mode  <= ctrl.start.ccd_mode;  // mode held for the whole run
          end
        end
        RUN_LOAD:
        begin
          if (stop_cmd)
            run_state <= RUN_PLAY;
        end
        RUN_PLAY:
        begin
          // leave only on a pixel boundary so the last pixel is complete
          if (pixel_start && sample_empty)
            run_state <= RUN_READ;
        end
        RUN_READ:
        begin
          if (capture_empty)
            run_state <= RUN_IDLE;
        end
        default:
          run_state <= RUN_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/afe_test_config.svh
`ifndef AFE_TEST_CONFIG_SVH
`define AFE_TEST_CONFIG_SVH

// fifo depths in 16-bit words
`define AFE_SAMPLE_DEPTH  256
`define AFE_CAPTURE_DEPTH 256

// valid_bus bit positions for the host channels
`define CH_VIDEO_SEL 0
`define CH_HDVD      1
`define CH_BLACK     2
`define CH_CTRL      3
`define CH_SAMPLES   4

// pixel and line geometry
`define PIXEL_CLOCKS 8   // sys_clk cycles per pixel
`define LINE_PIXELS  8   // pixels per clamp line
`define BLANK_PIXELS 2   // tail of the line with clamp off

`endif

//--- rtl/afe_test_pkg.sv
package afe_test_pkg;

  // run phases of one bench test
  typedef enum logic [1:0]
  {
    RUN_IDLE = 2'd0,
    RUN_LOAD = 2'd1,  // host fills the sample fifo
    RUN_PLAY = 2'd2,  // samples go to the dac, afe output is captured
    RUN_READ = 2'd3   // host drains the capture fifo
  } run_state_e;

  typedef logic [15:0] sample_word_t;
  typedef logic [13:0] dac_word_t;

  // start command layout of the control byte
  typedef struct packed
  {
    logic [3:0] tag;
    logic [2:0] rsvd;
    logic       ccd_mode;  // 1 = ccd, 0 = plain adc
  } ctrl_start_t;

  typedef union packed
  {
    logic [7:0]  raw;
    ctrl_start_t start;
  } ctrl_byte_u;

  localparam logic [3:0] CTRL_START_TAG = 4'hA;
  localparam logic [7:0] CTRL_STOP_CODE = 8'h55;

endpackage

//--- rtl/afe_test_top.sv
`timescale 1ns/1ps

`include "afe_test_config.svh"

module afe_test_top
  import afe_test_pkg::*;
(
  input  logic        sys_clk,
  input  logic        n_rst,
  input  logic [7:0]  master_data,
  input  logic [4:0]  valid_bus,
  input  logic        reply_rdreq,
  input  logic [11:0] q_fpga,
  output logic        reply_ready,
  output logic [7:0]  reply_len,
  output logic [7:0]  reply_data,
  output logic        video_in_select,
  output dac_word_t   dac_d,
  output logic        clk_fpga,
  output logic        shp_fpga,
  output logic        shd_fpga,
  output logic        hd_fpga,
  output logic        vd_fpga,
  output logic        clpdm_fpga
);

  run_state_e   run_state;
  logic         ccd_mode;
  logic [15:0]  black_level;
  sample_word_t sample_q;
  logic         sample_empty;
  logic         sample_wrreq;
  logic         sample_rdreq;
  logic         capture_wrreq;
  logic         capture_empty;
  logic [8:0]   capture_bytes;
  logic         pixel_start;

  // samples are accepted only between start and stop
  assign sample_wrreq = valid_bus[`CH_SAMPLES] && (run_state == RUN_LOAD);

  afe_reg_decoder u_reg_decoder
  (
    .sys_clk          (sys_clk),
    .n_rst            (n_rst),
    .master_data      (master_data),
    .video_sel_strobe (valid_bus[`CH_VIDEO_SEL]),
    .hdvd_strobe      (valid_bus[`CH_HDVD]),
    .black_strobe     (valid_bus[`CH_BLACK]),
    .video_in_select  (video_in_select),
    .hd_fpga          (hd_fpga),
    .vd_fpga          (vd_fpga),
    .black_level      (black_level)
  );

  afe_run_sequencer u_run_sequencer
  (
    .sys_clk       (sys_clk),
    .n_rst         (n_rst),
    .master_data   (master_data),
    .ctrl_strobe   (valid_bus[`CH_CTRL]),
    .sample_empty  (sample_empty),
    .capture_empty (capture_empty),
    .pixel_start   (pixel_start),
    .run_state     (run_state),
    .ccd_mode      (ccd_mode)
  );

  afe_pixel_timing u_pixel_timing
  (
    .sys_clk       (sys_clk),
    .n_rst         (n_rst),
    .run_state     (run_state),
    .ccd_mode      (ccd_mode),
    .black_level   (black_level),
    .sample_q      (sample_q),
    .sample_empty  (sample_empty),
    .sample_rdreq  (sample_rdreq),
    .capture_wrreq (capture_wrreq),
    .pixel_start   (pixel_start),
    .dac_d         (dac_d),
    .clk_fpga      (clk_fpga),
    .shp_fpga      (shp_fpga),
    .shd_fpga      (shd_fpga),
    .clpdm_fpga    (clpdm_fpga)
  );

  sample_pack_fifo #(.DEPTH(`AFE_SAMPLE_DEPTH)) u_sample_fifo
  (
    .sys_clk (sys_clk),
    .n_rst   (n_rst),
    .wr_byte (master_data),
    .wrreq   (sample_wrreq),
    .rdreq   (sample_rdreq),
    .q       (sample_q),
    .empty   (sample_empty)
  );

  capture_unpack_fifo #(.DEPTH(`AFE_CAPTURE_DEPTH)) u_capture_fifo
  (
    .sys_clk    (sys_clk),
    .n_rst      (n_rst),
    .wr_word    ({4'h0, q_fpga}),  // 12-bit afe code zero-extended
    .wrreq      (capture_wrreq),
    .rdreq      (reply_rdreq),
    .rd_byte    (reply_data),
    .empty      (capture_empty),
    .byte_count (capture_bytes)
  );

  assign reply_ready = (run_state == RUN_READ) && !capture_empty;
  assign reply_len   = (capture_bytes > 9'd255) ? 8'hff : capture_bytes[7:0];

endmodule

//--- rtl/capture_unpack_fifo.sv
`timescale 1ns/1ps

module capture_unpack_fifo
  import afe_test_pkg::*;
#(
  parameter int DEPTH = 256
)
(
  input  logic         sys_clk,
  input  logic         n_rst,
  input  sample_word_t wr_word,
  input  logic         wrreq,
  input  logic         rdreq,
  output logic [7:0]   rd_byte,
  output logic         empty,
  output logic [8:0]   byte_count
);

  localparam int AW       = $clog2(DEPTH);
  localparam int CW       = AW + 1;
  localparam int BYTE_MAX = 511;  // largest value byte_count can show

  sample_word_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          hi_sel;  // low byte of the head word already handed out
  logic          push;
  logic          rd_ok;
  logic          pop;
  logic [CW:0]   bytes_left;

  assign empty = (count == '0);
  assign push  = wrreq && (count != CW'(DEPTH));
  assign rd_ok = rdreq && !empty;
  assign pop   = rd_ok && hi_sel;  // word leaves after its high byte

  assign bytes_left = {count, 1'b0} - {{CW{1'b0}}, hi_sel};
  assign byte_count = (int'(bytes_left) > BYTE_MAX) ? 9'(BYTE_MAX) : 9'(bytes_left);

  always_ff @(posedge sys_clk)
  begin
    if (push)
      mem[wr_ptr] <= wr_word;
    if (rd_ok)
      rd_byte <= hi_sel ? mem[rd_ptr][15:8] : mem[rd_ptr][7:0];
  end

  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      hi_sel <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        hi_sel <= !hi_sel;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/sample_pack_fifo.sv
`timescale 1ns/1ps

module sample_pack_fifo
  import afe_test_pkg::*;
#(
  parameter int DEPTH = 256
)
(
  input  logic         sys_clk,
  input  logic         n_rst,
  input  logic [7:0]   wr_byte,
  input  logic         wrreq,
  input  logic         rdreq,
  output sample_word_t q,
  output logic         empty
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 1;

  sample_word_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [7:0]    low_byte;
  logic          have_low;  // first byte of a pair is waiting
  logic          push;
  logic          pop;

  assign empty = (count == '0);
  assign push  = wrreq && have_low && (count != CW'(DEPTH));  // full drops the word
  assign pop   = rdreq && !empty;
  assign q     = mem[rd_ptr];  // show-ahead head word

  always_ff @(posedge sys_clk)
  begin
    if (push)
      mem[wr_ptr] <= {wr_byte, low_byte};
  end

  always_ff @(posedge sys_clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      have_low <= 1'b0;
    end
    else
    begin
      if (wrreq)
        have_low <= !have_low;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (wrreq && !have_low)
      low_byte <= wr_byte;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_afe_test \
  -f sim.f -o tb_afe_test > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_afe_test > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "run failed"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- sim.f
+incdir+rtl
rtl/afe_test_pkg.sv
rtl/afe_reg_decoder.sv
rtl/afe_run_sequencer.sv
rtl/afe_pixel_timing.sv
rtl/sample_pack_fifo.sv
rtl/capture_unpack_fifo.sv
rtl/afe_test_top.sv
dv/tb_afe_test.sv
